// ==== hdl/frame_fifo.sv ====
`timescale 1ns/100ps

module frame_fifo (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] chk_data,
  input  logic                             chk_valid,
  input  logic                             chk_last,
  input  logic                             chk_bad,
  input  logic                             out_ready,
  output logic [frame_pkg::DATA_WIDTH-1:0] out_data,
  output logic                             out_valid,
  output logic                             out_last,
  output logic                             drop_bad,
  output logic                             drop_overflow
);

  // Entry holds the last flag above the data byte
  logic [frame_pkg::DATA_WIDTH:0] mem [2**frame_pkg::ADDR_WIDTH-1:0];
  logic [frame_pkg::DATA_WIDTH:0] out_reg;

  logic [frame_pkg::ADDR_WIDTH:0] wr_ptr;      // Committed frames end here
  logic [frame_pkg::ADDR_WIDTH:0] wr_ptr_cur;  // Frame being written
  logic [frame_pkg::ADDR_WIDTH:0] rd_ptr;

  logic discard;  // Rest of an overflowed frame is skipped
  logic full_cur;
  logic empty;
  logic wr_en;
  logic read;

  // Extra pointer bit tells a full memory from an empty one
  assign full_cur =
    (wr_ptr_cur[frame_pkg::ADDR_WIDTH] != rd_ptr[frame_pkg::ADDR_WIDTH]) &&
    (wr_ptr_cur[frame_pkg::ADDR_WIDTH-1:0] == rd_ptr[frame_pkg::ADDR_WIDTH-1:0]);

  assign empty = (wr_ptr == rd_ptr);  // Read side sees committed entries only

  assign wr_en = chk_valid & ~discard & ~full_cur;

  // Output register may be refilled while its beat is taken
  assign read = (out_ready | ~out_valid) & ~empty;

  assign {out_last, out_data} = out_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      wr_ptr_cur    <= '0;
      discard       <= 1'b0;
      drop_bad      <= 1'b0;
      drop_overflow <= 1'b0;
    end else begin
      drop_bad      <= 1'b0;
      drop_overflow <= 1'b0;
      if (chk_valid) begin
        if (discard | full_cur) begin
          // No room, roll back and wait for the end of the frame
          wr_ptr_cur    <= wr_ptr;
          discard       <= ~chk_last;
          drop_overflow <= chk_last;
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
          if (chk_last) begin
            if (chk_bad) begin
              wr_ptr_cur <= wr_ptr;
              drop_bad   <= 1'b1;
            end else begin
              wr_ptr <= wr_ptr_cur + 1'b1;  // Commit, frame now visible to read side
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_cur[frame_pkg::ADDR_WIDTH-1:0]] <= {chk_last, chk_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (out_ready | ~out_valid) begin
        out_valid <= ~empty;  // Holds until the transfer
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      out_reg <= mem[rd_ptr[frame_pkg::ADDR_WIDTH-1:0]];
    end
  end

endmodule

// ==== hdl/frame_pkg.sv ====
package frame_pkg;

  // Stream beat
  localparam int DATA_WIDTH = 8;

  // Frame FIFO storage, 2**ADDR_WIDTH beats
  localparam int ADDR_WIDTH = 4;

  // Legal frame length in beats
  localparam int MIN_FRAME_LEN = 2;
  localparam int MAX_FRAME_LEN = 12;

  // Checker beat counter, must hold MAX_FRAME_LEN + 2
  localparam int LEN_WIDTH = 4;

  // Statistics counters
  localparam int STAT_WIDTH = 16;

  // Position of the checker within a frame
  typedef enum logic [1:0] {
    CHK_FIRST = 2'd0,  // Next beat opens a frame
    CHK_BODY  = 2'd1,  // Inside a frame, length still legal
    CHK_LONG  = 2'd2   // Already past MAX_FRAME_LEN
  } check_state_t;

endpackage

// ==== hdl/frame_rx_path.sv ====
`timescale 1ns/100ps

module frame_rx_path (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] in_data,
  input  logic                             in_valid,
  input  logic                             in_last,
  input  logic                             in_err,
  input  logic                             out_ready,
  output logic [frame_pkg::DATA_WIDTH-1:0] out_data,
  output logic                             out_valid,
  output logic                             out_last,
  output logic [frame_pkg::STAT_WIDTH-1:0] good_count,
  output logic [frame_pkg::STAT_WIDTH-1:0] bad_count,
  output logic [frame_pkg::STAT_WIDTH-1:0] overflow_count
);

  logic [frame_pkg::DATA_WIDTH-1:0] chk_data;
  logic                             chk_valid;
  logic                             chk_last;
  logic                             chk_bad;

  logic drop_bad;
  logic drop_overflow;

  rx_frame_checker rx_frame_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_err    (in_err),
    .chk_data  (chk_data),
    .chk_valid (chk_valid),
    .chk_last  (chk_last),
    .chk_bad   (chk_bad)
  );

  frame_fifo frame_fifo_inst (
    .clk           (clk),
    .rst           (rst),
    .chk_data      (chk_data),
    .chk_valid     (chk_valid),
    .chk_last      (chk_last),
    .chk_bad       (chk_bad),
    .out_ready     (out_ready),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .drop_bad      (drop_bad),
    .drop_overflow (drop_overflow)
  );

  // Watches the output handshake next to the FIFO drop pulses
  frame_stats frame_stats_inst (
    .clk            (clk),
    .rst            (rst),
    .drop_bad       (drop_bad),
    .drop_overflow  (drop_overflow),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_last       (out_last),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule

// ==== hdl/frame_stats.sv ====
`timescale 1ns/100ps

module frame_stats (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             drop_bad,
  input  logic                             drop_overflow,
  input  logic                             out_valid,
  input  logic                             out_ready,
  input  logic                             out_last,
  output logic [frame_pkg::STAT_WIDTH-1:0] good_count,
  output logic [frame_pkg::STAT_WIDTH-1:0] bad_count,
  output logic [frame_pkg::STAT_WIDTH-1:0] overflow_count
);

  logic delivered;

  // Increment that sticks at all ones
  function automatic logic [frame_pkg::STAT_WIDTH-1:0] sat_inc(
    input logic [frame_pkg::STAT_WIDTH-1:0] value
  );
    if (&value) begin
      sat_inc = value;
    end else begin
      sat_inc = value + 1'b1;
    end
  endfunction

  assign delivered = out_valid & out_ready & out_last;  // Last beat transferred

  always_ff @(posedge clk) begin
    if (rst) begin
      good_count     <= '0;
      bad_count      <= '0;
      overflow_count <= '0;
    end else begin
      if (delivered) begin
        good_count <= sat_inc(good_count);
      end
      if (drop_bad) begin
        bad_count <= sat_inc(bad_count);
      end
      if (drop_overflow) begin
        overflow_count <= sat_inc(overflow_count);
      end
    end
  end

endmodule

// ==== hdl/rx_frame_checker.sv ====
`timescale 1ns/100ps

module rx_frame_checker (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] in_data,
  input  logic                             in_valid,
  input  logic                             in_last,
  input  logic                             in_err,
  output logic [frame_pkg::DATA_WIDTH-1:0] chk_data,
  output logic                             chk_valid,
  output logic                             chk_last,
  output logic                             chk_bad
);

  frame_pkg::check_state_t state;

  logic [frame_pkg::LEN_WIDTH-1:0] beat_cnt;  // Beats before the current one
  logic                            err_seen;  // Sticky in_err of this frame

  logic [frame_pkg::LEN_WIDTH-1:0] beat_len;
  logic                            err_any;
  logic                            len_bad;

  // Length and error status including the beat on the input
  always_comb begin
    beat_len = beat_cnt + 1'b1;
    err_any  = in_err | err_seen;
    if (state == frame_pkg::CHK_FIRST) begin
      beat_len = {{(frame_pkg::LEN_WIDTH - 1){1'b0}}, 1'b1};  // Stale count ignored
    end
    len_bad = (state == frame_pkg::CHK_LONG) ||
              (int'(beat_len) < frame_pkg::MIN_FRAME_LEN) ||
              (int'(beat_len) > frame_pkg::MAX_FRAME_LEN);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= frame_pkg::CHK_FIRST;
      beat_cnt  <= '0;
      err_seen  <= 1'b0;
      chk_valid <= 1'b0;
    end else begin
      chk_valid <= in_valid;
      if (in_valid) begin
        if (in_last) begin
          state    <= frame_pkg::CHK_FIRST;
          err_seen <= 1'b0;
        end else begin
          err_seen <= err_any;
          if (state != frame_pkg::CHK_LONG) begin  // Count freezes once too long
            beat_cnt <= beat_len;
            if (int'(beat_len) > frame_pkg::MAX_FRAME_LEN) begin
              state <= frame_pkg::CHK_LONG;
            end else begin
              state <= frame_pkg::CHK_BODY;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      chk_data <= in_data;
      chk_last <= in_last;
      chk_bad  <= in_last & (err_any | len_bad);  // Only valid on the last beat
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the frame receive path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module tb_frame_rx_path -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
if grep -qF '** PASS **' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb.f ====
hdl/frame_pkg.sv
hdl/rx_frame_checker.sv
hdl/frame_fifo.sv
hdl/frame_stats.sv
hdl/frame_rx_path.sv
tests/frame_monitor.sv
tests/tb_frame_rx_path.sv

// ==== tests/frame_monitor.sv ====
`timescale 1ns/100ps

module frame_monitor (
  input logic                             clk,
  input logic                             rst,
  input logic [frame_pkg::DATA_WIDTH-1:0] out_data,
  input logic                             out_valid,
  input logic                             out_ready,
  input logic                             out_last,
  input logic [frame_pkg::STAT_WIDTH-1:0] good_count,
  input logic [frame_pkg::STAT_WIDTH-1:0] bad_count,
  input logic [frame_pkg::STAT_WIDTH-1:0] overflow_count
);

  logic [frame_pkg::DATA_WIDTH:0] expected [$];  // Last flag above the byte
  logic [frame_pkg::DATA_WIDTH:0] exp_beat;
  int mismatch_count = 0;
  int fail_count = 0;

  task automatic expect_beat(input logic [frame_pkg::DATA_WIDTH-1:0] data, input logic last);
    expected.push_back({last, data});
  endtask

  task automatic check_idle();
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("Mismatch at %0t: out_valid high after reset", $time);
      mismatch_count++;
    end
  endtask

  // Handshake seen mid cycle transfers at the next rising edge
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (expected.size() == 0) begin
        $display("Mismatch at %0t: unexpected beat %h last %b", $time, out_data, out_last);
        mismatch_count++;
      end else begin
        exp_beat = expected.pop_front();
        if ({out_last, out_data} !== exp_beat) begin
          $display("Mismatch at %0t: got %h last %b, expected %h last %b", $time,
                   out_data, out_last, exp_beat[frame_pkg::DATA_WIDTH-1:0],
                   exp_beat[frame_pkg::DATA_WIDTH]);
          mismatch_count++;
        end
      end
    end
  end

  task automatic compare_count(input string name, input logic [frame_pkg::STAT_WIDTH-1:0] got,
                               input logic [frame_pkg::STAT_WIDTH-1:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
      mismatch_count++;
    end
  endtask

  task automatic final_check(input logic [frame_pkg::STAT_WIDTH-1:0] want_good,
                             input logic [frame_pkg::STAT_WIDTH-1:0] want_bad,
                             input logic [frame_pkg::STAT_WIDTH-1:0] want_overflow);
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < 400) begin
      @(negedge clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("Timeout at %0t: %0d expected beats never came out", $time, expected.size());
      fail_count++;
    end
    repeat (4) @(negedge clk);  // Counters settle
    compare_count("good_count", good_count, want_good);
    compare_count("bad_count", bad_count, want_bad);
    compare_count("overflow_count", overflow_count, want_overflow);
  endtask

endmodule

// ==== tests/tb_frame_rx_path.sv ====
`timescale 1ns/100ps

module tb_frame_rx_path;

  typedef enum logic [1:0] {READY_HIGH, READY_RAND, READY_LOW} ready_mode_t;
  typedef enum logic [1:0] {EXP_GOOD, EXP_BAD, EXP_OVERFLOW} outcome_t;

  typedef struct packed {
    int          len;
    int          err_beat;  // -1 when no beat carries in_err
    ready_mode_t mode;
    outcome_t    outcome;
  } frame_row_t;

  frame_row_t frame_table [16] = '{
    '{2,  -1, READY_HIGH, EXP_GOOD},
    '{12, -1, READY_HIGH, EXP_GOOD},
    '{5,   2, READY_HIGH, EXP_BAD},
    '{1,  -1, READY_HIGH, EXP_BAD},       // Too short
    '{13, -1, READY_HIGH, EXP_BAD},       // Too long
    '{7,  -1, READY_RAND, EXP_GOOD},
    '{12, -1, READY_RAND, EXP_GOOD},
    '{3,   0, READY_RAND, EXP_BAD},
    '{10, -1, READY_LOW,  EXP_GOOD},      // Output stalled from here
    '{8,  -1, READY_LOW,  EXP_OVERFLOW},
    '{5,  -1, READY_LOW,  EXP_GOOD},
    '{14, -1, READY_LOW,  EXP_OVERFLOW},  // Bad length as well
    '{6,  -1, READY_RAND, EXP_GOOD},
    '{4,   3, READY_HIGH, EXP_BAD},
    '{9,  -1, READY_HIGH, EXP_GOOD},
    '{15, -1, READY_HIGH, EXP_BAD}
  };

  logic clk = 1'b0;
  logic rst;
  logic [frame_pkg::DATA_WIDTH-1:0] in_data;
  logic in_valid;
  logic in_last;
  logic in_err;
  logic out_ready;
  logic [frame_pkg::DATA_WIDTH-1:0] out_data;
  logic out_valid;
  logic out_last;
  logic [frame_pkg::STAT_WIDTH-1:0] good_count;
  logic [frame_pkg::STAT_WIDTH-1:0] bad_count;
  logic [frame_pkg::STAT_WIDTH-1:0] overflow_count;

  logic [31:0] rng;
  ready_mode_t ready_mode;
  logic [frame_pkg::STAT_WIDTH-1:0] exp_good;
  logic [frame_pkg::STAT_WIDTH-1:0] exp_bad;
  logic [frame_pkg::STAT_WIDTH-1:0] exp_overflow;
  int timeout_count;
  int other_errors;

  always #10 clk = ~clk;

  frame_rx_path frame_rx_path_inst (
    .clk            (clk),
    .rst            (rst),
    .in_data        (in_data),
    .in_valid       (in_valid),
    .in_last        (in_last),
    .in_err         (in_err),
    .out_ready      (out_ready),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_last       (out_last),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  frame_monitor frame_monitor_inst (
    .clk            (clk),
    .rst            (rst),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_last       (out_last),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One rising edge, out_ready follows the current mode
  task automatic step_clock();
    @(posedge clk);
    rng = xorshift(rng);
    case (ready_mode)
      READY_HIGH: out_ready <= 1'b1;
      READY_RAND: out_ready <= rng[16];
      default:    out_ready <= 1'b0;
    endcase
  endtask

  // Output idle for 4 cycles means the FIFO is empty
  task automatic wait_idle();
    int low_cycles;
    int waited;
    low_cycles = 0;
    waited = 0;
    if (ready_mode == READY_LOW) begin
      ready_mode = READY_HIGH;
    end
    while (low_cycles < 4 && waited < 200) begin
      step_clock();
      @(negedge clk);
      if (out_valid) begin
        low_cycles = 0;
      end else begin
        low_cycles++;
      end
      waited++;
    end
    if (low_cycles < 4) begin
      $display("Timeout at %0t: output did not go idle", $time);
      timeout_count++;
    end
  endtask

  task automatic send_frame(input frame_row_t row);
    logic [frame_pkg::DATA_WIDTH-1:0] payload;
    for (int i = 0; i < row.len; i++) begin
      step_clock();
      payload = rng[frame_pkg::DATA_WIDTH-1:0];
      in_data  <= payload;
      in_valid <= 1'b1;
      in_last  <= (i == row.len - 1);
      in_err   <= (i == row.err_beat);
      if (row.outcome == EXP_GOOD) begin
        frame_monitor_inst.expect_beat(payload, i == row.len - 1);
      end
    end
    step_clock();
    in_valid <= 1'b0;
    in_last  <= 1'b0;
    in_err   <= 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    in_err = 1'b0;
    out_ready = 1'b1;
    rng = 32'h8830_e481;
    ready_mode = READY_HIGH;
    exp_good = '0;
    exp_bad = '0;
    exp_overflow = '0;
    timeout_count = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    frame_monitor_inst.check_idle();
    for (int r = 0; r < 16 && timeout_count == 0; r++) begin
      // Consecutive stall rows share one filling FIFO
      if (!(r > 0 && frame_table[r].mode == READY_LOW && frame_table[r-1].mode == READY_LOW)) begin
        wait_idle();
      end
      ready_mode = frame_table[r].mode;
      case (frame_table[r].outcome)
        EXP_GOOD: exp_good++;
        EXP_BAD:  exp_bad++;
        default:  exp_overflow++;
      endcase
      send_frame(frame_table[r]);
    end
    if (timeout_count == 0) begin
      wait_idle();
    end
    if (timeout_count == 0) begin
      frame_monitor_inst.final_check(exp_good, exp_bad, exp_overflow);
    end
    other_errors = timeout_count + frame_monitor_inst.fail_count;
    $display("Errors: %0d mismatches, %0d other failures",
             frame_monitor_inst.mismatch_count, other_errors);
    if (frame_monitor_inst.mismatch_count == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
